// File: common/sched_cfg_pkg.sv
`default_nettype none

package sched_cfg_pkg;

  // Each picker serves one cluster of four hardware threads
  localparam int THREADS_PER_CLUSTER = 4;

  // Bits needed to name a thread inside its cluster
  localparam int TID_WIDTH = 2;

  // Cluster count used when the top level is not overridden
  localparam int DEFAULT_CLUSTERS = 4;

  // Round robin scan direction of a picker
  // It flips each time a round of service completes
  typedef enum logic {
    PICK_FWD = 1'b0,
    PICK_REV = 1'b1
  } pick_dir_t;

endpackage

`default_nettype wire

// File: common/sched_op_pkg.sv
`default_nettype none

package sched_op_pkg;

  // Commands accepted on the router control port
  // All of them act on the single thread named by cmd_thread
  typedef enum logic [1:0] {
    OP_NOP       = 2'd0,
    OP_SET_FORCE = 2'd1,
    OP_CLR_FORCE = 2'd2,
    OP_FLUSH     = 2'd3
  } sched_op_t;

endpackage

`default_nettype wire

// File: common/pick_if.sv
`timescale 1ns/10ps
`default_nettype none

interface pick_if;

  // Pending events and force mask of the cluster
  logic [sched_cfg_pkg::THREADS_PER_CLUSTER-1:0] events;
  logic [sched_cfg_pkg::THREADS_PER_CLUSTER-1:0] force_mask;

  // One-hot choice of the picker that is zero only with no events
  logic [sched_cfg_pkg::THREADS_PER_CLUSTER-1:0] pick;

  // The pick as accepted by the collector and zero under stall
  logic [sched_cfg_pkg::THREADS_PER_CLUSTER-1:0] picked;

  modport router (
    output events,
    output force_mask,
    input  picked
  );

  modport picker (
    input  events,
    input  force_mask,
    input  picked,
    output pick
  );

  modport collector (
    input  pick,
    output picked
  );

endinterface

`default_nettype wire

// File: picker/thread_picker.sv
`timescale 1ns/10ps
`default_nettype none

module thread_picker (
  input logic    clk,
  input logic    reset,
  pick_if.picker port
);

  localparam int n = sched_cfg_pkg::THREADS_PER_CLUSTER;

  logic [n-1:0]              history_q;
  sched_cfg_pkg::pick_dir_t  dir_q;

  logic [n-1:0] force_hits;
  logic [n-1:0] force_1hot;
  logic         any_force;
  logic [n-1:0] rr_events;
  logic [n-1:0] rr_cand;
  logic [n-1:0] fwd_1hot;
  logic [n-1:0] rev_1hot;
  logic [n-1:0] status;
  logic [n-1:0] open_events;

  // Forced threads that also have an event win with the lowest index first
  assign force_hits = port.events & port.force_mask;
  assign any_force  = |force_hits;

  assign force_1hot[0] = force_hits[0];
  assign force_1hot[1] = force_hits[1] & ~force_hits[0];
  assign force_1hot[2] = force_hits[2] & ~|force_hits[1:0];
  assign force_1hot[3] = force_hits[3] & ~|force_hits[2:0];

  // Threads already served this round are skipped
  assign rr_events = port.events & ~history_q;

  // A flush can remove the last unserved event of a round, so fall back to
  // all events and keep the pick non-zero while anything is pending
  assign rr_cand = (|rr_events) ? rr_events : port.events;

  assign fwd_1hot[0] = rr_cand[0];
  assign fwd_1hot[1] = rr_cand[1] & ~rr_cand[0];
  assign fwd_1hot[2] = rr_cand[2] & ~|rr_cand[1:0];
  assign fwd_1hot[3] = rr_cand[3] & ~|rr_cand[2:0];

  assign rev_1hot[3] = rr_cand[3];
  assign rev_1hot[2] = rr_cand[2] & ~rr_cand[3];
  assign rev_1hot[1] = rr_cand[1] & ~|rr_cand[3:2];
  assign rev_1hot[0] = rr_cand[0] & ~|rr_cand[3:1];

  always_comb begin
    if (any_force) begin
      port.pick = force_1hot;
    end else if (dir_q == sched_cfg_pkg::PICK_REV) begin
      port.pick = rev_1hot;
    end else begin
      port.pick = fwd_1hot;
    end
  end

  // Status counts the thread accepted in this cycle as served
  assign status      = history_q | port.picked;
  assign open_events = port.events & ~status;

  always_ff @(posedge clk) begin
    if (reset) begin
      history_q <= '0;
      dir_q     <= sched_cfg_pkg::PICK_FWD;
    end else if (|open_events) begin
      history_q <= status;
    end else begin
      // A completed round starts over and scans the other way
      history_q <= '0;
      if (|port.events) begin
        dir_q <= (dir_q == sched_cfg_pkg::PICK_FWD) ? sched_cfg_pkg::PICK_REV
                                                    : sched_cfg_pkg::PICK_FWD;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/event_router.sv
`timescale 1ns/10ps
`default_nettype none

module event_router #(
  parameter int num_clusters = sched_cfg_pkg::DEFAULT_CLUSTERS,
  localparam int num_threads = num_clusters * sched_cfg_pkg::THREADS_PER_CLUSTER,
  localparam int thread_idx_width = $clog2(num_threads)
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [num_threads-1:0]      ready,
  input  logic                        cmd_valid,
  input  sched_op_pkg::sched_op_t     cmd_op,
  input  logic [thread_idx_width-1:0] cmd_thread,
  pick_if.router                      clusters [num_clusters]
);

  localparam int tpc = sched_cfg_pkg::THREADS_PER_CLUSTER;

  logic [num_threads-1:0] event_q;
  logic [num_threads-1:0] force_q;
  logic [num_threads-1:0] picked_all;
  logic [num_threads-1:0] cmd_sel;
  logic [num_threads-1:0] flush_sel;
  logic [num_threads-1:0] set_sel;
  logic [num_threads-1:0] clr_sel;

  // One-hot decode of the addressed global thread
  always_comb begin
    cmd_sel = '0;
    if (cmd_valid) begin
      cmd_sel[cmd_thread] = 1'b1;
    end
  end

  always_comb begin
    flush_sel = '0;
    set_sel   = '0;
    clr_sel   = '0;
    case (cmd_op)
      sched_op_pkg::OP_SET_FORCE: set_sel   = cmd_sel;
      sched_op_pkg::OP_CLR_FORCE: clr_sel   = cmd_sel;
      sched_op_pkg::OP_FLUSH:     flush_sel = cmd_sel;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      event_q <= '0;
      force_q <= '0;
    end else begin
      // A ready pulse in the same cycle overrides both kinds of clear
      event_q <= (event_q & ~picked_all & ~flush_sel) | ready;
      force_q <= (force_q & ~clr_sel) | set_sel;
    end
  end

  for (genvar c = 0; c < num_clusters; c++) begin : g_slice
    assign clusters[c].events     = event_q[c*tpc +: tpc];
    assign clusters[c].force_mask = force_q[c*tpc +: tpc];
    assign picked_all[c*tpc +: tpc] = clusters[c].picked;
  end

endmodule

`default_nettype wire

// File: source/issue_collector.sv
`timescale 1ns/10ps
`default_nettype none

module issue_collector #(
  parameter int num_clusters = sched_cfg_pkg::DEFAULT_CLUSTERS
) (
  input  logic                                           clk,
  input  logic                                           reset,
  input  logic [num_clusters-1:0]                        stall,
  pick_if.collector                                      clusters [num_clusters],
  output logic [num_clusters-1:0]                        issue_valid,
  output logic [num_clusters*sched_cfg_pkg::TID_WIDTH-1:0] issue_tid
);

  localparam int tpc = sched_cfg_pkg::THREADS_PER_CLUSTER;
  localparam int tw  = sched_cfg_pkg::TID_WIDTH;

  // Index of the set bit of a one-hot pick
  function automatic logic [tw-1:0] encode_tid(input logic [tpc-1:0] onehot);
    logic [tw-1:0] tid;
    tid = '0;
    for (int i = 0; i < tpc; i++) begin
      if (onehot[i]) begin
        tid = i[tw-1:0];
      end
    end
    return tid;
  endfunction

  for (genvar c = 0; c < num_clusters; c++) begin : g_cluster
    logic [tpc-1:0] accepted;
    logic           valid_q;
    logic [tw-1:0]  tid_q;

    // A stalled cluster accepts nothing, so its events and history hold
    assign accepted           = stall[c] ? '0 : clusters[c].pick;
    assign clusters[c].picked = accepted;

    always_ff @(posedge clk) begin
      if (reset) begin
        valid_q <= 1'b0;
      end else begin
        valid_q <= |accepted;
      end
    end

    always_ff @(posedge clk) begin
      tid_q <= encode_tid(accepted);
    end

    assign issue_valid[c]          = valid_q;
    assign issue_tid[c*tw +: tw]   = tid_q;
  end

endmodule

`default_nettype wire

// File: source/thread_sched_top.sv
`timescale 1ns/10ps
`default_nettype none

module thread_sched_top #(
  parameter int num_clusters = sched_cfg_pkg::DEFAULT_CLUSTERS,
  localparam int num_threads = num_clusters * sched_cfg_pkg::THREADS_PER_CLUSTER,
  localparam int thread_idx_width = $clog2(num_threads)
) (
  input  logic                                             clk,
  input  logic                                             reset,
  input  logic [num_threads-1:0]                           ready,
  input  logic                                             cmd_valid,
  input  sched_op_pkg::sched_op_t                          cmd_op,
  input  logic [thread_idx_width-1:0]                      cmd_thread,
  input  logic [num_clusters-1:0]                          stall,
  output logic [num_clusters-1:0]                          issue_valid,
  output logic [num_clusters*sched_cfg_pkg::TID_WIDTH-1:0] issue_tid
);

  // One link per cluster between router, picker and collector
  pick_if clusters [num_clusters] ();

  event_router #(
    .num_clusters (num_clusters)
  ) u_router (
    .clk        (clk),
    .reset      (reset),
    .ready      (ready),
    .cmd_valid  (cmd_valid),
    .cmd_op     (cmd_op),
    .cmd_thread (cmd_thread),
    .clusters   (clusters)
  );

  for (genvar c = 0; c < num_clusters; c++) begin : g_picker
    thread_picker u_picker (
      .clk   (clk),
      .reset (reset),
      .port  (clusters[c])
    );
  end

  issue_collector #(
    .num_clusters (num_clusters)
  ) u_collector (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .clusters    (clusters),
    .issue_valid (issue_valid),
    .issue_tid   (issue_tid)
  );

endmodule

`default_nettype wire

// File: test/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
  parameter int half_period_ns = 2,
  parameter int reset_cycles   = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(half_period_ns) clk = ~clk;
  end

  // Reset drops on a rising edge, so the DUT sees it low from the next edge on
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: test/thread_sched_chk.sv
`timescale 1ns/10ps
`default_nettype none

module thread_sched_chk (
  input logic                                          clk,
  input logic                                          reset,
  input logic [sched_cfg_pkg::THREADS_PER_CLUSTER-1:0] events,
  input logic [sched_cfg_pkg::THREADS_PER_CLUSTER-1:0] pick
);

  // At most one thread leaves a cluster per cycle
  a_pick_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(pick))
    else $error("pick %b is not one-hot or zero", pick);

  // Only a thread with a pending event can be chosen
  a_pick_subset: assert property (@(posedge clk) disable iff (reset)
    (pick & ~events) == '0)
    else $error("pick %b selects a thread without an event, events %b", pick, events);

  // The picker never idles while work is pending
  a_pick_busy: assert property (@(posedge clk) disable iff (reset)
    (events != '0) |-> (pick != '0))
    else $error("pick is zero while events is %b", events);

endmodule

bind thread_picker thread_sched_chk u_chk (
  .clk    (clk),
  .reset  (reset),
  .events (port.events),
  .pick   (port.pick)
);

`default_nettype wire

// File: test/thread_sched_tb.sv
`timescale 1ns/10ps
`default_nettype none

module thread_sched_tb;

  localparam int num_clusters  = 4;
  localparam int tpc           = sched_cfg_pkg::THREADS_PER_CLUSTER;
  localparam int tw            = sched_cfg_pkg::TID_WIDTH;
  localparam int num_threads   = num_clusters * tpc;
  localparam int random_cycles = 2000;
  // Tests 1 to 4 and the directed part of test 5 take about 85 cycles
  localparam int directed_cycles = 100;
  localparam int watchdog_ns = (10 + directed_cycles + random_cycles) * 4 + 400;

  logic                       clk;
  logic                       reset;
  logic [num_threads-1:0]     ready;
  logic                       cmd_valid;
  sched_op_pkg::sched_op_t    cmd_op;
  logic [3:0]                 cmd_thread;
  logic [num_clusters-1:0]    stall;
  logic [num_clusters-1:0]    issue_valid;
  logic [num_clusters*tw-1:0] issue_tid;

  // Reference state of each cluster
  logic [tpc-1:0]           m_events [num_clusters];
  logic [tpc-1:0]           m_force [num_clusters];
  logic [tpc-1:0]           m_hist [num_clusters];
  sched_cfg_pkg::pick_dir_t m_dir [num_clusters];
  logic                     exp_valid [num_clusters];
  logic [tw-1:0]            exp_tid [num_clusters];

  int          errors;
  int          checks;
  int          tests_passed;
  int          tests_failed;
  int          issue_cnt [num_threads];
  int          order_q [$];
  logic [31:0] rng;

  clock_gen u_clock (.clk (clk), .reset (reset));

  thread_sched_top #(
    .num_clusters (num_clusters)
  ) UUT (
    .clk         (clk),
    .reset       (reset),
    .ready       (ready),
    .cmd_valid   (cmd_valid),
    .cmd_op      (cmd_op),
    .cmd_thread  (cmd_thread),
    .stall       (stall),
    .issue_valid (issue_valid),
    .issue_tid   (issue_tid)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Forced events win lowest index first, and otherwise unserved events go in scan order
  function automatic logic [tpc-1:0] model_pick(input logic [tpc-1:0] ev,
      input logic [tpc-1:0] frc, input logic [tpc-1:0] hist,
      input sched_cfg_pkg::pick_dir_t dir);
    logic [tpc-1:0] cand;
    logic [tpc-1:0] result;
    logic           high_first;
    int             idx;
    result = '0;
    if ((ev & frc) != '0) begin
      cand       = ev & frc;
      high_first = 1'b0;
    end else begin
      cand = ev & ~hist;
      if (cand == '0) begin
        cand = ev;
      end
      high_first = (dir == sched_cfg_pkg::PICK_REV);
    end
    // The last match wins, so scan towards the preferred end
    for (int i = 0; i < tpc; i++) begin
      idx = high_first ? i : tpc - 1 - i;
      if (cand[idx]) begin
        result = '0;
        result[idx] = 1'b1;
      end
    end
    return result;
  endfunction

  task automatic check_outputs();
    logic [tw-1:0] tid;
    for (int c = 0; c < num_clusters; c++) begin
      tid = issue_tid[c*tw +: tw];
      checks++;
      assert (issue_valid[c] == exp_valid[c]) else begin
        $display("Fail %0t issue_valid[%0d] got %b expected %b", $time, c,
                 issue_valid[c], exp_valid[c]);
        errors++;
      end
      if (issue_valid[c] && exp_valid[c]) begin
        assert (tid == exp_tid[c]) else begin
          $display("Fail %0t issue_tid[%0d] got %0d expected %0d", $time, c, tid, exp_tid[c]);
          errors++;
        end
      end
      if (issue_valid[c]) begin
        issue_cnt[c*tpc + int'(tid)]++;
        if (c == 0) begin
          order_q.push_back(int'(tid));
        end
      end
    end
  endtask

  // Each call checks the last cycle's issue, drives the inputs and advances the model
  task automatic cycle(input logic [num_threads-1:0] ready_v, input logic cmd_v,
      input sched_op_pkg::sched_op_t op_v, input logic [3:0] thread_v,
      input logic [num_clusters-1:0] stall_v);
    logic [tpc-1:0] pk;
    logic [tpc-1:0] acc;
    logic [tpc-1:0] status;
    logic [tpc-1:0] cmd_bit;
    int             cmd_cluster;
    @(negedge clk);
    check_outputs();
    ready      = ready_v;
    cmd_valid  = cmd_v;
    cmd_op     = op_v;
    cmd_thread = thread_v;
    stall      = stall_v;
    cmd_cluster = int'(thread_v[3:tw]);
    cmd_bit = '0;
    if (cmd_v) begin
      cmd_bit[thread_v[tw-1:0]] = 1'b1;
    end
    for (int c = 0; c < num_clusters; c++) begin
      pk  = model_pick(m_events[c], m_force[c], m_hist[c], m_dir[c]);
      acc = stall_v[c] ? '0 : pk;
      exp_valid[c] = |acc;
      for (int i = 0; i < tpc; i++) begin
        if (acc[i]) begin
          exp_tid[c] = tw'(i);
        end
      end
      status = m_hist[c] | acc;
      if ((m_events[c] & ~status) != '0) begin
        m_hist[c] = status;
      end else begin
        m_hist[c] = '0;
        if (m_events[c] != '0) begin
          m_dir[c] = (m_dir[c] == sched_cfg_pkg::PICK_FWD) ? sched_cfg_pkg::PICK_REV
                                                           : sched_cfg_pkg::PICK_FWD;
        end
      end
      m_events[c] = m_events[c] & ~acc;
      if (c == cmd_cluster && op_v == sched_op_pkg::OP_FLUSH) begin
        m_events[c] = m_events[c] & ~cmd_bit;
      end
      if (c == cmd_cluster && op_v == sched_op_pkg::OP_SET_FORCE) begin
        m_force[c] = m_force[c] | cmd_bit;
      end
      if (c == cmd_cluster && op_v == sched_op_pkg::OP_CLR_FORCE) begin
        m_force[c] = m_force[c] & ~cmd_bit;
      end
      m_events[c] = m_events[c] | ready_v[c*tpc +: tpc];
    end
  endtask

  task automatic idle(input int n);
    repeat (n) cycle('0, 1'b0, sched_op_pkg::OP_NOP, 4'd0, '0);
  endtask

  task automatic command(input sched_op_pkg::sched_op_t op_v, input logic [3:0] thread_v);
    cycle('0, 1'b1, op_v, thread_v, '0);
  endtask

  task automatic clear_counts();
    for (int t = 0; t < num_threads; t++) begin
      issue_cnt[t] = 0;
    end
    order_q.delete();
  endtask

  task automatic expect_count(input int thread, input int want);
    assert (issue_cnt[thread] == want) else begin
      $display("Fail %0t issue count of thread %0d got %0d expected %0d", $time, thread,
               issue_cnt[thread], want);
      errors++;
    end
  endtask

  task automatic expect_order(input int o0, input int o1, input int o2, input int o3);
    int want [4];
    want = '{o0, o1, o2, o3};
    assert (order_q.size() == 4) else begin
      $display("Cluster 0 issued %0d threads where four were expected", order_q.size());
      errors++;
    end
    for (int i = 0; i < 4 && i < order_q.size(); i++) begin
      assert (order_q[i] == want[i]) else begin
        $display("Fail %0t cluster 0 issue order[%0d] got %0d expected %0d", $time, i,
                 order_q[i], want[i]);
        errors++;
      end
    end
    order_q.delete();
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns before the tests completed", watchdog_ns);
    $display("Verification failed");
    $finish;
  end

  initial begin
    logic [num_threads-1:0]  r_ready;
    logic [num_clusters-1:0] r_stall;
    logic                    r_cmd;
    int                      errors_before;
    ready      = '0;
    cmd_valid  = 1'b0;
    cmd_op     = sched_op_pkg::OP_NOP;
    cmd_thread = '0;
    stall      = '0;
    errors = 0;
    checks = 0;
    tests_passed = 0;
    tests_failed = 0;
    rng = 32'd71;
    for (int c = 0; c < num_clusters; c++) begin
      m_events[c]  = '0;
      m_force[c]   = '0;
      m_hist[c]    = '0;
      m_dir[c]     = sched_cfg_pkg::PICK_FWD;
      exp_valid[c] = 1'b0;
      exp_tid[c]   = '0;
    end
    clear_counts();
    wait (reset == 1'b0);

    errors_before = errors;
    idle(20);
    for (int t = 0; t < num_threads; t++) begin
      expect_count(t, 0);
    end
    report_test("1 idle after reset", errors_before);

    errors_before = errors;
    clear_counts();
    cycle(16'h000f, 1'b0, sched_op_pkg::OP_NOP, 4'd0, '0);
    idle(8);
    expect_order(0, 1, 2, 3);
    cycle(16'h000f, 1'b0, sched_op_pkg::OP_NOP, 4'd0, '0);
    idle(8);
    expect_order(3, 2, 1, 0);
    report_test("2 round robin", errors_before);

    errors_before = errors;
    command(sched_op_pkg::OP_SET_FORCE, 4'd1);
    command(sched_op_pkg::OP_SET_FORCE, 4'd2);
    cycle(16'h000f, 1'b0, sched_op_pkg::OP_NOP, 4'd0, '0);
    idle(8);
    expect_order(1, 2, 0, 3);
    command(sched_op_pkg::OP_CLR_FORCE, 4'd1);
    command(sched_op_pkg::OP_CLR_FORCE, 4'd2);
    cycle(16'h000f, 1'b0, sched_op_pkg::OP_NOP, 4'd0, '0);
    idle(8);
    expect_order(3, 2, 1, 0);
    report_test("3 force override", errors_before);

    errors_before = errors;
    clear_counts();
    cycle(16'h00f0, 1'b0, sched_op_pkg::OP_NOP, 4'd0, 4'b0010);
    repeat (3) cycle('0, 1'b0, sched_op_pkg::OP_NOP, 4'd0, 4'b0010);
    idle(1);
    for (int t = 4; t < 8; t++) begin
      expect_count(t, 0);
    end
    idle(8);
    for (int t = 4; t < 8; t++) begin
      expect_count(t, 1);
    end
    report_test("4 stall", errors_before);

    errors_before = errors;
    clear_counts();
    cycle(16'h0200, 1'b0, sched_op_pkg::OP_NOP, 4'd0, 4'b0100);
    cycle('0, 1'b1, sched_op_pkg::OP_FLUSH, 4'd9, 4'b0100);
    idle(8);
    expect_count(9, 0);
    for (int n = 0; n < random_cycles; n++) begin
      r_ready = '0;
      for (int t = 0; t < num_threads; t++) begin
        rng = xorshift32(rng);
        r_ready[t] = (rng[3:0] == 4'd0);
      end
      r_stall = '0;
      for (int c = 0; c < num_clusters; c++) begin
        rng = xorshift32(rng);
        r_stall[c] = ((rng % 32'd5) == 32'd0);
      end
      rng = xorshift32(rng);
      r_cmd = (rng[2:0] == 3'd0);
      cycle(r_ready, r_cmd, sched_op_pkg::sched_op_t'(rng[5:4]), rng[11:8], r_stall);
    end
    idle(10);
    // The issue of the last idle cycle is still to be compared
    @(negedge clk);
    check_outputs();
    report_test("5 flush and random", errors_before);

    $display("Tests passed %0d failed %0d, checks %0d, errors %0d", tests_passed,
             tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
common/sched_cfg_pkg.sv
common/sched_op_pkg.sv
common/pick_if.sv
picker/thread_picker.sv
source/event_router.sv
source/issue_collector.sv
source/thread_sched_top.sv
test/clock_gen.sv
test/thread_sched_chk.sv
test/thread_sched_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := thread_sched_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := Verification passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
